// File: build.f
verilog/mem_map_pkg.sv
verilog/cpu_access_if.sv
verilog/address_decoder.sv
verilog/scratchpad_ram.sv
verilog/sdram_access_sequencer.sv
verilog/read_data_return.sv
verilog/mem_subsystem_top.sv
tests/sdram_ctrl_stub.sv
tests/tb_mem_subsystem.sv

// File: Bender.yml
package:
  name: mem_subsystem

sources:
  - files:
      - verilog/mem_map_pkg.sv
      - verilog/cpu_access_if.sv
      - verilog/address_decoder.sv
      - verilog/scratchpad_ram.sv
      - verilog/sdram_access_sequencer.sv
      - verilog/read_data_return.sv
      - verilog/mem_subsystem_top.sv
  - target: test
    files:
      - tests/sdram_ctrl_stub.sv
      - tests/tb_mem_subsystem.sv

// File: tests/tb_mem_subsystem.sv
// Memory subsystem testbench
`default_nettype none

module tb_mem_subsystem;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int BUSY_TIMEOUT = mem_map_pkg::BUSY_TIMEOUT_DEFAULT;
  localparam int WAIT_LIMIT   = 200;                        // Cycles per busy wait
  localparam mem_map_pkg::word_addr_t PAD_BASE = 23'h004000; // Byte 08000

  logic                    clk;
  logic                    i_rst_n;
  mem_map_pkg::word_addr_t i_adr;
  mem_map_pkg::bus_data_t  i_data;
  logic                    i_we_n;
  logic                    i_oe_n;
  logic                    i_lb_n;
  logic                    i_ub_n;
  logic                    i_addr_strobe;
  mem_map_pkg::bus_data_t  o_data;
  logic                    o_memory_busy;
  logic                    o_use_memory_busy;
  logic                    o_ext_as;
  mem_map_pkg::ext_addr_t  o_ext_addr;
  mem_map_pkg::bus_data_t  o_ext_wdata;
  logic                    o_ext_wr_n;
  mem_map_pkg::bus_data_t  i_ext_rdata;
  logic                    i_ext_done;
  logic                    timeout_mode;                    // Stub stops answering

  integer                 seed = 32'ha972;
  int                     mismatches = 0;
  int                     timeouts   = 0;
  mem_map_pkg::bus_data_t pad_model [512];                  // Scratchpad reference
  mem_map_pkg::bus_data_t ext_model [mem_map_pkg::ext_addr_t]; // SDRAM words written

  mem_subsystem_top dut_i (
    .clk (clk), .i_rst_n (i_rst_n), .i_adr (i_adr), .i_data (i_data),
    .i_we_n (i_we_n), .i_oe_n (i_oe_n), .i_lb_n (i_lb_n), .i_ub_n (i_ub_n),
    .i_addr_strobe (i_addr_strobe), .o_data (o_data), .o_memory_busy (o_memory_busy),
    .o_use_memory_busy (o_use_memory_busy), .o_ext_as (o_ext_as),
    .o_ext_addr (o_ext_addr), .o_ext_wdata (o_ext_wdata), .o_ext_wr_n (o_ext_wr_n),
    .i_ext_rdata (i_ext_rdata), .i_ext_done (i_ext_done)
  );

  sdram_ctrl_stub stub_i (
    .clk (clk), .i_rst_n (i_rst_n), .i_timeout_mode (timeout_mode), .i_ext_as (o_ext_as),
    .i_ext_addr (o_ext_addr), .i_ext_wdata (o_ext_wdata), .i_ext_wr_n (o_ext_wr_n),
    .o_ext_rdata (i_ext_rdata), .o_ext_done (i_ext_done)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ==========================================================================
  // Reference model
  // ==========================================================================
  function automatic logic [31:0] next_random();
    return $random(seed);
  endfunction

  // External window as {first byte, last byte}
  function automatic logic [47:0] window_range(input int w);
    case (w)
      0:       return {24'h000000, 24'h001fff};             // Console ROM
      1:       return {24'h002000, 24'h003fff};             // Low RAM
      2:       return {24'h00a000, 24'h00bfff};
      3:       return {24'h00c000, 24'h00ffff};
      4:       return {24'h010000, 24'h01ffff};             // GROM
      5:       return {24'h030000, 24'h03ffff};             // DSR ROM
      6:       return {24'h100000, 24'h1fffff};             // SAMS
      7:       return {24'h200000, 24'h3fffff};             // Cartridges
      default: return {24'h400000, 24'h5fffff};             // Test window
    endcase
  endfunction

  function automatic mem_map_pkg::region_e expected_region(input mem_map_pkg::word_addr_t adr);
    logic [23:0] byte_adr;
    logic [47:0] range;
    byte_adr = {adr, 1'b0};
    if (byte_adr >= 24'h008000 && byte_adr <= 24'h0083ff)
      return mem_map_pkg::REGION_PAD;
    for (int w = 0; w < 9; w++)
    begin
      range = window_range(w);
      if (byte_adr >= range[47:24] && byte_adr <= range[23:0])
        return mem_map_pkg::REGION_EXT;
    end
    return mem_map_pkg::REGION_NONE;
  endfunction

  function automatic mem_map_pkg::word_addr_t random_ext_adr();
    logic [47:0] range;
    logic [23:0] byte_adr;
    range    = window_range(int'(next_random() % 9));
    byte_adr = range[47:24] + 24'(next_random() % (range[23:0] - range[47:24] + 1));
    return byte_adr[23:1];
  endfunction

  // Stub word as written or as filled
  function automatic mem_map_pkg::bus_data_t expected_ext(input mem_map_pkg::ext_addr_t a);
    if (ext_model.exists(a))
      return ext_model[a];
    return {a[7:0], a[23:16]} ^ a[15:0] ^ 16'h5a3c;
  endfunction

  // ==========================================================================
  // Compare tasks
  // ==========================================================================
  task automatic report_mismatch(input string name, input logic [31:0] got, exp);
    mismatches++;
    $display("mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
  endtask

  task automatic compare_data(input string name, input mem_map_pkg::bus_data_t got, exp);
    if (got !== exp)
      report_mismatch(name, got, exp);
  endtask

  task automatic compare_addr(input string name, input mem_map_pkg::ext_addr_t got, exp);
    if (got !== exp)
      report_mismatch(name, got, exp);
  endtask

  task automatic compare_bit(input string name, input logic got, exp);
    if (got !== exp)
      report_mismatch(name, got, exp);
  endtask

  task automatic compare_count(input string name, input int got, exp);
    if (got != exp)
      report_mismatch(name, got, exp);
  endtask

  // ==========================================================================
  // Bus tasks driven on the falling edge
  // ==========================================================================
  task automatic drive_bus(input mem_map_pkg::word_addr_t adr, input mem_map_pkg::bus_data_t data,
                           input logic wr, rd, input logic [1:0] lanes_n, input logic strobe);
    i_adr         <= adr;
    i_data        <= data;
    i_we_n        <= !wr;
    i_oe_n        <= !rd;
    {i_ub_n, i_lb_n} <= lanes_n;
    i_addr_strobe <= strobe;
  endtask

  task automatic drive_idle();
    drive_bus(i_adr, i_data, 1'b0, 1'b0, 2'b11, 1'b0);      // Address held
  endtask

  task automatic pad_access(input mem_map_pkg::pad_index_t idx, input mem_map_pkg::bus_data_t data,
                            input logic wr, input logic [1:0] lanes_n);
    @(negedge clk);
    drive_bus(PAD_BASE + idx, data, wr, !wr, lanes_n, 1'b1);
    if (wr && !lanes_n[0])
      pad_model[idx][7:0] = data[7:0];
    if (wr && !lanes_n[1])
      pad_model[idx][15:8] = data[15:8];
    @(negedge clk);                                          // Registered read settled
    if (!wr)
      compare_data("o_data", o_data, pad_model[idx]);
    compare_bit("o_ext_as", o_ext_as, 1'b0);
    drive_idle();
  endtask

  task automatic ext_access(input mem_map_pkg::word_addr_t adr, input logic wr,
                            input mem_map_pkg::bus_data_t data);
    mem_map_pkg::ext_addr_t ext_adr;
    int                     cycles;
    logic                   acked;
    ext_adr = {1'b0, adr};
    @(negedge clk);
    drive_bus(adr, data, wr, !wr, 2'b00, 1'b1);
    @(negedge clk);                                          // One cycle after the strobe
    compare_bit("o_ext_as", o_ext_as, 1'b1);
    compare_addr("o_ext_addr", o_ext_addr, ext_adr);
    compare_bit("o_ext_wr_n", o_ext_wr_n, !wr);
    compare_bit("o_memory_busy", o_memory_busy, 1'b1);
    if (wr)
    begin
      compare_data("o_ext_wdata", o_ext_wdata, data);
      ext_model[ext_adr] = data;
    end
    i_addr_strobe <= 1'b0;
    cycles = 0;
    acked  = 1'b0;
    while (o_memory_busy && !acked && cycles < WAIT_LIMIT)
    begin
      @(posedge clk);
      acked = i_ext_done;                                    // Ack as the sequencer sees it
      @(negedge clk);
      compare_bit("o_ext_as", o_ext_as, 1'b0);                // Single pulse only
      cycles++;
    end
    if (o_memory_busy && !acked)
    begin
      timeouts++;
      $display("timeout: o_memory_busy stuck high for address %h", adr);
    end
    else
    begin
      // Busy drops in the cycle after the ack and not before it
      compare_bit("o_memory_busy", o_memory_busy, !acked);
      if (!wr)
        compare_data("o_data", o_data, expected_ext(ext_adr));
    end
    drive_idle();
  endtask

  // Stub silent so busy runs the full count
  task automatic timeout_access(input mem_map_pkg::word_addr_t adr);
    int high_cycles;
    @(negedge clk);
    timeout_mode <= 1'b1;
    drive_bus(adr, '0, 1'b0, 1'b1, 2'b00, 1'b1);
    @(negedge clk);
    i_addr_strobe <= 1'b0;
    high_cycles = 0;
    while (o_memory_busy && high_cycles < WAIT_LIMIT)
    begin
      high_cycles++;
      @(negedge clk);
    end
    if (o_memory_busy)
    begin
      timeouts++;
      $display("timeout: o_memory_busy never fell in timeout mode");
    end
    compare_count("o_memory_busy high cycles", high_cycles, BUSY_TIMEOUT);
    timeout_mode <= 1'b0;
    drive_idle();
  endtask

  // Decode check with no SDRAM access started
  task automatic decode_check(input mem_map_pkg::word_addr_t adr, input logic wr, rd);
    mem_map_pkg::region_e region;
    logic                 wr_eff;
    region = expected_region(adr);
    wr_eff = wr && (region != mem_map_pkg::REGION_PAD);      // Keep pad model intact
    @(negedge clk);
    drive_bus(adr, 16'hffff, wr_eff, rd, 2'b00, region != mem_map_pkg::REGION_EXT);
    @(negedge clk);
    compare_bit("o_use_memory_busy", o_use_memory_busy,
                (region == mem_map_pkg::REGION_EXT) && (wr_eff || rd));
    compare_bit("o_ext_as", o_ext_as, 1'b0);
    compare_bit("o_memory_busy", o_memory_busy, 1'b0);
    if (region == mem_map_pkg::REGION_NONE)
      compare_data("o_data", o_data, '0);
    drive_idle();
  endtask

  // ==========================================================================
  // Test sequence
  // ==========================================================================
  initial
  begin
    logic [31:0]             rnd;
    mem_map_pkg::word_addr_t adr;
    i_rst_n = 1'b0;
    i_adr = '0;
    i_data = '0;
    i_we_n = 1'b1;
    i_oe_n = 1'b1;
    i_lb_n = 1'b1;
    i_ub_n = 1'b1;
    i_addr_strobe = 1'b0;
    timeout_mode = 1'b0;
    repeat (8) @(negedge clk);
    i_rst_n <= 1'b1;
    for (int i = 0; i < 512; i++)                           // Fill pad on both lanes
    begin
      rnd = next_random();
      pad_access(i[8:0], rnd[15:0], 1'b1, 2'b00);
    end
    for (int i = 0; i < 400; i++)                           // Mixed lane traffic
    begin
      rnd = next_random();
      pad_access(rnd[8:0], rnd[31:16], rnd[11], rnd[10:9]);
    end
    for (int i = 0; i < 40; i++)
      ext_access(random_ext_adr(), 1'b0, '0);
    for (int i = 0; i < 40; i++)                            // Write, then read back
    begin
      adr = random_ext_adr();
      rnd = next_random();
      ext_access(adr, 1'b1, rnd[15:0]);
      ext_access(adr, 1'b0, '0);
    end
    adr = random_ext_adr();
    timeout_access(adr);
    ext_access(adr, 1'b0, '0);                              // Recovers after timeout
    for (int i = 0; i < 400; i++)
    begin
      rnd = next_random();
      adr = rnd[31] ? {7'd0, rnd[15:0]} : rnd[22:0];         // Bias toward low 128K
      decode_check(adr, rnd[24], rnd[25]);
    end
    $display("mismatches %0d, timeouts %0d", mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: tests/sdram_ctrl_stub.sv
// Behavioral SDRAM controller
`default_nettype none

module sdram_ctrl_stub (
  input  wire                         clk,
  input  wire                         i_rst_n,
  input  wire                         i_timeout_mode,   // Swallow requests, never ack
  input  wire                         i_ext_as,
  input  wire mem_map_pkg::ext_addr_t i_ext_addr,
  input  wire mem_map_pkg::bus_data_t i_ext_wdata,
  input  wire                         i_ext_wr_n,
  output mem_map_pkg::bus_data_t      o_ext_rdata,
  output logic                        o_ext_done
);

  timeunit 1ns;
  timeprecision 1ps;

  integer                 seed = 32'ha972;
  mem_map_pkg::bus_data_t mem [mem_map_pkg::ext_addr_t];   // Sparse, written words only
  mem_map_pkg::ext_addr_t adr_q;                           // Request held while pending
  mem_map_pkg::bus_data_t wdata_q;
  logic                   wr_q;
  logic                   pending;
  int                     delay;                           // Cycles left until ack

  // Unwritten words, every address bit folded in
  function automatic mem_map_pkg::bus_data_t fill_word(input mem_map_pkg::ext_addr_t a);
    return {a[7:0], a[23:16]} ^ a[15:0] ^ 16'h5a3c;
  endfunction

  // Outputs move on the falling edge
  always @(negedge clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      pending     <= 1'b0;
      delay       <= 0;
      o_ext_done  <= 1'b0;
      o_ext_rdata <= '0;
    end
    else
    begin
      o_ext_done <= 1'b0;                                  // Ack is a single pulse
      if (i_ext_as)
      begin
        pending <= !i_timeout_mode;
        delay   <= 1 + int'($unsigned($random(seed)) % 20);
        adr_q   <= i_ext_addr;
        wdata_q <= i_ext_wdata;
        wr_q    <= !i_ext_wr_n;
      end
      else if (pending)
      begin
        if (delay > 1)
          delay <= delay - 1;
        else
        begin
          pending    <= 1'b0;
          o_ext_done <= 1'b1;
          if (wr_q)
            mem[adr_q] = wdata_q;
          o_ext_rdata <= mem.exists(adr_q) ? mem[adr_q] : fill_word(adr_q);
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/mem_subsystem_top.sv
// Console memory subsystem top
`default_nettype none

module mem_subsystem_top #(
  parameter int BUSY_TIMEOUT = mem_map_pkg::BUSY_TIMEOUT_DEFAULT
) (
  input  wire                         clk,
  input  wire                         i_rst_n,
  // CPU bus
  input  wire mem_map_pkg::word_addr_t i_adr,
  input  wire mem_map_pkg::bus_data_t  i_data,
  input  wire                          i_we_n,
  input  wire                          i_oe_n,
  input  wire                          i_lb_n,
  input  wire                          i_ub_n,
  input  wire                          i_addr_strobe,
  output mem_map_pkg::bus_data_t       o_data,
  output logic                         o_memory_busy,
  output logic                         o_use_memory_busy,
  // SDRAM controller
  output logic                         o_ext_as,
  output mem_map_pkg::ext_addr_t       o_ext_addr,
  output mem_map_pkg::bus_data_t       o_ext_wdata,
  output logic                         o_ext_wr_n,
  input  wire mem_map_pkg::bus_data_t  i_ext_rdata,
  input  wire                          i_ext_done
);

  cpu_access_if acc_if ();

  mem_map_pkg::bus_data_t pad_rdata;            // Scratchpad to read mux

  // ==========================================================================
  // Decode
  // ==========================================================================
  address_decoder decoder_i (
    .i_adr         (i_adr),
    .i_data        (i_data),
    .i_we_n        (i_we_n),
    .i_oe_n        (i_oe_n),
    .i_lb_n        (i_lb_n),
    .i_ub_n        (i_ub_n),
    .i_addr_strobe (i_addr_strobe),
    .acc           (acc_if.decoder)
  );

  // ==========================================================================
  // Execute
  // ==========================================================================
  scratchpad_ram pad_i (
    .clk     (clk),
    .acc     (acc_if.pad),
    .o_rdata (pad_rdata)
  );

  sdram_access_sequencer #(
    .BUSY_TIMEOUT (BUSY_TIMEOUT)
  ) seq_i (
    .clk               (clk),
    .i_rst_n           (i_rst_n),
    .acc               (acc_if.ext),
    .i_ext_done        (i_ext_done),
    .o_ext_as          (o_ext_as),
    .o_ext_addr        (o_ext_addr),
    .o_ext_wdata       (o_ext_wdata),
    .o_ext_wr_n        (o_ext_wr_n),
    .o_memory_busy     (o_memory_busy),
    .o_use_memory_busy (o_use_memory_busy)
  );

  // Result
  read_data_return result_i (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .acc         (acc_if.result),
    .i_pad_rdata (pad_rdata),
    .i_ext_rdata (i_ext_rdata),
    .i_ext_done  (i_ext_done),
    .o_data      (o_data)
  );

endmodule

`default_nettype wire

// File: verilog/read_data_return.sv
// CPU read data return
`default_nettype none

module read_data_return (
  input  wire                         clk,
  input  wire                         i_rst_n,
  cpu_access_if.result                acc,
  input  wire mem_map_pkg::bus_data_t i_pad_rdata,   // Registered scratchpad data
  input  wire mem_map_pkg::bus_data_t i_ext_rdata,   // Valid with done
  input  wire                         i_ext_done,
  output mem_map_pkg::bus_data_t      o_data
);

  mem_map_pkg::bus_data_t ext_data_q;           // Last SDRAM read word

  // Capture on ack, held until the next one
  always_ff @(posedge clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
      ext_data_q <= '0;
    else if (i_ext_done)
      ext_data_q <= i_ext_rdata;
  end

  // Read bus mux by current region
  always_comb
  begin
    case (acc.region)
      mem_map_pkg::REGION_PAD: o_data = i_pad_rdata;
      mem_map_pkg::REGION_EXT: o_data = ext_data_q;
      default:                 o_data = '0;   // Unmapped reads zero
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/sdram_access_sequencer.sv
// SDRAM access sequencer
`default_nettype none

module sdram_access_sequencer #(
  parameter int BUSY_TIMEOUT = mem_map_pkg::BUSY_TIMEOUT_DEFAULT
) (
  input  wire                         clk,
  input  wire                         i_rst_n,
  cpu_access_if.ext                   acc,
  input  wire                         i_ext_done,          // Controller ack pulse
  output logic                        o_ext_as,            // Delayed strobe
  output mem_map_pkg::ext_addr_t      o_ext_addr,
  output mem_map_pkg::bus_data_t      o_ext_wdata,
  output logic                        o_ext_wr_n,
  output logic                        o_memory_busy,       // CPU wait states
  output logic                        o_use_memory_busy    // CPU should honor busy
);

  localparam mem_map_pkg::busy_count_t BUSY_LOAD = mem_map_pkg::busy_count_t'(BUSY_TIMEOUT);

  logic                     is_ext;               // Address in an SDRAM window
  logic                     ext_strobe;           // Start of an external access
  logic                     ext_as_q;
  mem_map_pkg::busy_count_t busy_count;

  assign is_ext     = (acc.region == mem_map_pkg::REGION_EXT);
  assign ext_strobe = acc.strobe && is_ext;

  // ==========================================================================
  // Strobe delay
  // ==========================================================================
  // Controller sees the strobe one cycle late, address already settled
  always_ff @(posedge clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
      ext_as_q <= 1'b0;
    else
      ext_as_q <= ext_strobe;
  end

  assign o_ext_as = ext_as_q;

  // ==========================================================================
  // Wait-state counter
  // ==========================================================================
  always_ff @(posedge clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
      busy_count <= '0;
    else if (ext_strobe)                          // New access wins over done
      busy_count <= BUSY_LOAD;
    else if (i_ext_done)                          // Controller finished
      busy_count <= '0;
    else if (busy_count != '0)
      busy_count <= busy_count - 1'b1;            // Timeout run-down
  end

  assign o_memory_busy = (busy_count != '0);

  // Busy only matters for SDRAM regions
  assign o_use_memory_busy = is_ext && (acc.rd || acc.wr);

  // ==========================================================================
  // Controller request fields
  // ==========================================================================
  // Follow the CPU bus, held steady for the whole access
  assign o_ext_addr  = {1'b0, acc.adr};
  assign o_ext_wdata = acc.wdata;
  assign o_ext_wr_n  = ~acc.wr;

endmodule

`default_nettype wire

// File: verilog/scratchpad_ram.sv
// Scratchpad RAM
`default_nettype none

module scratchpad_ram (
  input  wire                         clk,
  cpu_access_if.pad                   acc,
  output mem_map_pkg::bus_data_t      o_rdata
);

  localparam int DEPTH = 1 << mem_map_pkg::PAD_INDEX_W;

  // One array per byte lane
  logic [7:0] mem_lo [DEPTH];
  logic [7:0] mem_hi [DEPTH];

  mem_map_pkg::pad_index_t idx;                 // Low address bits
  logic                    pad_wr;              // Write into this region
  logic [7:0]              rd_lo_q;
  logic [7:0]              rd_hi_q;

  assign idx    = acc.adr[mem_map_pkg::PAD_INDEX_W-1:0];
  assign pad_wr = (acc.region == mem_map_pkg::REGION_PAD) && acc.wr;

  // Low lane
  always_ff @(posedge clk)
  begin
    if (pad_wr && acc.lb_en)
      mem_lo[idx] <= acc.wdata[7:0];
    rd_lo_q <= mem_lo[idx];                     // Read every cycle
  end

  // High lane
  always_ff @(posedge clk)
  begin
    if (pad_wr && acc.ub_en)
      mem_hi[idx] <= acc.wdata[15:8];
    rd_hi_q <= mem_hi[idx];
  end

  assign o_rdata = {rd_hi_q, rd_lo_q};

endmodule

`default_nettype wire

// File: verilog/address_decoder.sv
// CPU address decoder
`default_nettype none

module address_decoder (
  input  wire mem_map_pkg::word_addr_t i_adr,
  input  wire mem_map_pkg::bus_data_t  i_data,
  input  wire                          i_we_n,
  input  wire                          i_oe_n,
  input  wire                          i_lb_n,
  input  wire                          i_ub_n,
  input  wire                          i_addr_strobe,
  cpu_access_if.decoder                acc
);

  // Top-bit compare of one external window
  function automatic logic window_hit(
    input mem_map_pkg::word_addr_t  adr,
    input mem_map_pkg::ext_window_t win
  );
    logic [mem_map_pkg::WORD_ADDR_W:0] low_ones;
    mem_map_pkg::word_addr_t           mask;
    // Ones below the compared field
    low_ones = ({{mem_map_pkg::WORD_ADDR_W{1'b0}}, 1'b1}
                << (mem_map_pkg::WORD_ADDR_W - win.top_bits)) - 1'b1;
    mask     = ~low_ones[mem_map_pkg::WORD_ADDR_W-1:0];
    return (adr & mask) == win.base;
  endfunction

  logic pad_hit;                                // Scratchpad window
  logic ext_hit;                                // Any SDRAM window

  // ==========================================================================
  // Region match
  // ==========================================================================
  assign pad_hit = (i_adr[mem_map_pkg::WORD_ADDR_W-1:mem_map_pkg::PAD_INDEX_W]
                    == mem_map_pkg::PAD_MATCH);

  always_comb
  begin
    ext_hit = 1'b0;
    for (int i = 0; i < mem_map_pkg::EXT_WINDOW_COUNT; i++)
    begin
      if (window_hit(i_adr, mem_map_pkg::EXT_WINDOWS[i]))
        ext_hit = 1'b1;
    end
  end

  // Windows are disjoint, pad checked first anyway
  always_comb
  begin
    if (pad_hit)
      acc.region = mem_map_pkg::REGION_PAD;
    else if (ext_hit)
      acc.region = mem_map_pkg::REGION_EXT;
    else
      acc.region = mem_map_pkg::REGION_NONE;
  end

  // ==========================================================================
  // Access fields
  // ==========================================================================
  assign acc.adr    = i_adr;
  assign acc.wdata  = i_data;
  assign acc.wr     = ~i_we_n;                  // Strobes to active high
  assign acc.rd     = ~i_oe_n;
  assign acc.lb_en  = ~i_lb_n;
  assign acc.ub_en  = ~i_ub_n;
  assign acc.strobe = i_addr_strobe;            // Same cycle as the CPU

endmodule

`default_nettype wire

// File: verilog/cpu_access_if.sv
// Decoded CPU access
`default_nettype none

interface cpu_access_if;

  mem_map_pkg::region_e    region;        // Region of the current address
  mem_map_pkg::word_addr_t adr;           // Word address as held by the CPU
  mem_map_pkg::bus_data_t  wdata;         // CPU write data
  logic                    wr;            // Write level
  logic                    rd;            // Read level
  logic                    lb_en;         // Low byte lane
  logic                    ub_en;         // High byte lane
  logic                    strobe;        // One-cycle start of access

  // Decoder side
  modport decoder (output region, adr, wdata, wr, rd, lb_en, ub_en, strobe);

  // Scratchpad RAM, byte-lane writes
  modport pad (input region, adr, wdata, wr, lb_en, ub_en);

  // SDRAM sequencer
  modport ext (input region, adr, wdata, wr, rd, strobe);

  // Read data mux only needs the region
  modport result (input region);

endinterface

`default_nettype wire

// File: verilog/mem_map_pkg.sv
// Console memory map definitions
`default_nettype none

package mem_map_pkg;

  // ==========================================================================
  // Bus widths and types
  // ==========================================================================
  localparam int WORD_ADDR_W = 23;              // CPU word address
  localparam int PAD_INDEX_W = 9;               // 512 words = 1K bytes

  typedef logic [WORD_ADDR_W-1:0] word_addr_t;
  typedef logic [WORD_ADDR_W:0]   ext_addr_t;   // Extra zero top bit for SDRAM
  typedef logic [15:0]            bus_data_t;
  typedef logic [PAD_INDEX_W-1:0] pad_index_t;
  typedef logic [6:0]             busy_count_t;

  typedef enum logic [1:0] {
    REGION_NONE,                                // Unmapped, reads as zero
    REGION_PAD,                                 // On-chip scratchpad
    REGION_EXT                                  // Anything served by SDRAM
  } region_e;

  // ==========================================================================
  // Region match values
  // ==========================================================================
  // Word address bits 22:9, byte address 08000
  localparam logic [WORD_ADDR_W-PAD_INDEX_W-1:0] PAD_MATCH = 14'b0000_0000_1000_00;

  // Window = number of top address bits compared, plus the word base address
  typedef struct packed {
    logic [4:0] top_bits;
    word_addr_t base;
  } ext_window_t;

  localparam int EXT_WINDOW_COUNT = 9;

  localparam ext_window_t EXT_WINDOWS [EXT_WINDOW_COUNT] = '{
    '{5'd11, 23'h000000},                       // Console ROM, byte 0000
    '{5'd11, 23'h001000},                       // Low RAM, byte 2000 (8K)
    '{5'd11, 23'h005000},                       // High RAM, byte A000 (8K)
    '{5'd10, 23'h006000},                       // High RAM, byte C000..FFFF
    '{5'd8,  23'h008000},                       // GROM, byte 10000
    '{5'd8,  23'h018000},                       // DSR ROM, byte 30000
    '{5'd4,  23'h080000},                       // SAMS 1M..2M
    '{5'd3,  23'h100000},                       // Cartridges 2M..4M
    '{5'd3,  23'h200000}                        // Test window 4M..6M
  };

  localparam int BUSY_TIMEOUT_DEFAULT = 100;    // Wait-state load value

endpackage

`default_nettype wire
